/* sim/softmax_checker.sv */
`timescale 1ns/100ps

module softmax_checker (
  input  logic                       clk,
  input  logic                       rst,
  input  softmax_vec_pkg::in_beat_t  in_data,
  input  logic                       in_valid,
  input  logic                       in_ready,
  input  softmax_vec_pkg::out_beat_t out_data,
  input  logic                       out_valid,
  input  logic                       out_last,
  input  logic                       out_ready,
  output int                         mismatches,
  output int                         other_errors,
  output int                         pending
);
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  in_elem_t  vec_q [$];       // elements of the vector still arriving
  out_beat_t exp_data_q [$];
  logic      exp_last_q [$];

  // e**(code/16) in Q8.8, nearest, kept within 1..65535
  function automatic longint ref_exp(input int code);
    real v;
    v = $exp(code / 16.0) * 256.0;
    if (v >= 65535.0) return 65535;
    v = $floor(v + 0.5);
    if (v < 1.0) return 1;
    return longint'($rtoi(v));
  endfunction

  // probability in Q0.8 with round half up, capped at 255
  function automatic longint ref_prob(input longint e, input longint total);
    longint q;
    longint p;
    q = (e * 512) / total;
    p = (q + 1) / 2;
    if (p > 255) p = 255;
    return p;
  endfunction

  function automatic void queue_expected();
    longint    e [vec_len];
    longint    total;
    out_beat_t beat;
    total = 0;
    for (int i = 0; i < vec_len; i++) begin
      e[i] = ref_exp(int'(vec_q[i]));
      total += e[i];
    end
    for (int b = 0; b < beats_per_vec; b++) begin
      for (int l = 0; l < lanes; l++) begin
        beat[l] = out_elem_t'(ref_prob(e[b*lanes + l], total));
      end
      exp_data_q.push_back(beat);
      exp_last_q.push_back(b == beats_per_vec - 1);
    end
    vec_q.delete();
  endfunction

  initial begin
    mismatches   = 0;
    other_errors = 0;
    pending      = 0;
  end

  always @(posedge clk) begin
    out_beat_t want;
    logic      want_last;
    if (!rst) begin
      if (in_valid && in_ready) begin
        for (int l = 0; l < lanes; l++) vec_q.push_back(in_data[l]);  // lane 0 first
        if (vec_q.size() == vec_len) queue_expected();
      end
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          $display("%0t: output beat arrived with no expected beat left", $time);
          other_errors++;
        end else begin
          want      = exp_data_q.pop_front();
          want_last = exp_last_q.pop_front();
          for (int l = 0; l < lanes; l++) begin
            if (out_data[l] !== want[l]) begin
              $display("[ERROR] %0t out_data[%0d] expected %0d actual %0d",
                       $time, l, want[l], out_data[l]);
              mismatches++;
            end
          end
          if (out_last !== want_last) begin
            $display("[ERROR] %0t out_last expected %0b actual %0b",
                     $time, want_last, out_last);
            mismatches++;
          end
        end
      end
      pending = exp_data_q.size();
    end
  end

endmodule

/* sim/softmax_tb.sv */
`timescale 1ns/100ps

module softmax_tb;
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  localparam int n_random  = 200;
  localparam int n_bp      = 100;
  localparam int n_gap     = 100;
  localparam int n_vectors = 3 + n_random + n_bp + n_gap;
  localparam int wd_ns     = n_vectors * beats_per_vec * 20 * 10 + 1000;

  logic      clk;
  logic      rst;
  in_beat_t  in_data;
  logic      in_valid;
  logic      in_ready;
  out_beat_t out_data;
  logic      out_valid;
  logic      out_last;
  logic      out_ready;

  in_elem_t vec [vec_len];  // vector being sent
  int       hold_pct;       // percent of cycles with out_ready low
  int       stalls;
  int       tb_errors;
  int       drain;
  int       mismatches;
  int       other_errors;
  int       pending;

  softmax_top i_softmax_top (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

  softmax_checker i_softmax_checker (
    .clk          (clk),
    .rst          (rst),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_last     (out_last),
    .out_ready    (out_ready),
    .mismatches   (mismatches),
    .other_errors (other_errors),
    .pending      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // output back-pressure
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge clk);
      out_ready = ($urandom % 100) >= hold_pct;
    end
  end

  initial begin
    #(wd_ns);
    $display("watchdog: run did not finish within %0d ns", wd_ns);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic send_vector(input int gap_max);
    for (int b = 0; b < beats_per_vec; b++) begin
      if (gap_max > 0) begin
        in_valid = 1'b0;
        repeat ($urandom % (gap_max + 1)) @(negedge clk);
      end
      for (int l = 0; l < lanes; l++) in_data[l] = vec[b*lanes + l];
      in_valid = 1'b1;
      while (!in_ready) begin  // hold beat until taken
        stalls++;
        @(negedge clk);
      end
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic fill_random();
    for (int i = 0; i < vec_len; i++) vec[i] = in_elem_t'($urandom);
  endtask

  initial begin
    void'($urandom(81971));
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    hold_pct  = 0;
    stalls    = 0;
    tb_errors = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    vec = '{default: in_elem_t'(16)};  // equal elements, 1/8 each
    send_vector(0);
    vec = '{default: in_elem_t'(-48)};
    send_vector(0);
    vec    = '{default: in_elem_t'(-128)};
    vec[5] = in_elem_t'(126);  // lone winner near 7.9
    send_vector(0);

    repeat (n_random) begin
      fill_random();
      send_vector(0);
    end

    hold_pct = 60;
    stalls   = 0;
    repeat (n_bp) begin
      fill_random();
      send_vector(0);
    end
    if (stalls == 0) begin
      $display("in_ready never dropped while the output was held back");
      tb_errors++;
    end

    hold_pct = 40;
    repeat (n_gap) begin
      fill_random();
      send_vector(3);
    end

    hold_pct = 0;
    drain    = 0;
    while (pending != 0 && drain < 500) begin
      @(negedge clk);
      drain++;
    end
    repeat (10) @(negedge clk);  // catch stray beats
    if (pending != 0) begin
      $display("%0d expected output beats never appeared", pending);
      tb_errors++;
    end
    $display("errors: %0d value mismatches, %0d other", mismatches, other_errors + tb_errors);
    if (mismatches + other_errors + tb_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* softmax.f */
verilog/softmax_fmt_pkg.sv
verilog/softmax_vec_pkg.sv
verilog/beat_if.sv
verilog/beat_fifo.sv
verilog/exp_decode.sv
verilog/sum_accumulate.sv
verilog/normalize_round.sv
verilog/softmax_top.sv
sim/softmax_checker.sv
sim/softmax_tb.sv

/* verilog/beat_fifo.sv */
`timescale 1ns/100ps

module beat_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;
  typedef logic [$clog2(depth+1)-1:0] count_t;

  payload_t mem [depth];  // no reset, guarded by count
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  count_t   count;
  logic     wr;
  logic     rd;

  assign in_ready  = (count != count_t'(depth));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign wr = in_valid && in_ready;
  assign rd = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd) rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= in_data;
  end

  // write pointer leads read pointer by the occupancy, so no unread entry is overwritten
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % depth);

  // a valid head was written before, never a slot read from empty
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !$isunknown(out_data));

endmodule

/* verilog/beat_if.sv */
`timescale 1ns/100ps

// one beat of lanes plus vector end flag, valid/ready handshake
interface beat_if #(
  parameter type payload_t = logic
) ();

  payload_t data;
  logic     last;   // final beat of a vector
  logic     valid;
  logic     ready;

  modport src (
    output data,
    output last,
    output valid,
    input  ready
  );

  modport snk (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

/* verilog/exp_decode.sv */
`timescale 1ns/100ps

module exp_decode (
  input  logic                      clk,
  input  logic                      rst,
  input  softmax_vec_pkg::in_beat_t in_data,
  input  logic                      in_valid,
  output logic                      in_ready,
  beat_if.src                       exp_out
);
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  exp_elem_t exp_tab [2**in_width];  // indexed by raw input code
  exp_beat_t exp_d;
  exp_beat_t data_q;
  logic      last_q;
  logic      valid_q;
  beat_cnt_t cnt;
  logic      accept;
  logic      is_last;

  // table is constant, folded at elaboration
  for (genvar c = 0; c < 2**in_width; c++) begin : g_tab
    assign exp_tab[c] = exp_entry(in_elem_t'(c));
  end

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      exp_d[l] = exp_tab[$unsigned(in_data[l])];
    end
  end

  assign is_last  = (cnt == beat_cnt_t'(beats_per_vec - 1));
  assign in_ready = !valid_q || exp_out.ready;  // empty or draining
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      cnt     <= '0;
    end else begin
      if (in_ready) valid_q <= in_valid;
      if (accept) cnt <= is_last ? '0 : cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= exp_d;
      last_q <= is_last;
    end
  end

  assign exp_out.data  = data_q;
  assign exp_out.last  = last_q;
  assign exp_out.valid = valid_q;

  // stalled beat must hold until taken
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    exp_out.valid && !exp_out.ready |=>
      exp_out.valid && $stable(exp_out.data) && $stable(exp_out.last));

endmodule

/* verilog/normalize_round.sv */
`timescale 1ns/100ps

module normalize_round (
  input  logic                       clk,
  input  logic                       rst,
  beat_if.snk                        norm_in,
  input  softmax_fmt_pkg::sum_t      sum,
  input  logic                       sum_valid,
  output logic                       sum_ready,
  output softmax_vec_pkg::out_beat_t out_data,
  output logic                       out_valid,
  output logic                       out_last,
  input  logic                       out_ready
);
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  // exponent scaled by 2**(out_frac+1), one spare bit for rounding
  typedef logic [exp_width+out_frac:0] num_t;

  num_t      quot [lanes];
  num_t      half [lanes];
  out_beat_t res;
  logic      out_free;
  logic      fire;

  assign out_free = !out_valid || out_ready;
  assign fire     = norm_in.valid && sum_valid && out_free;

  // beat waits for its vector sum
  assign norm_in.ready = sum_valid && out_free;
  // sum stays until the vector's last beat goes
  assign sum_ready     = norm_in.valid && norm_in.last && out_free;

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      quot[l] = (num_t'(norm_in.data[l]) << (out_frac + 1)) / num_t'(sum);
      half[l] = (quot[l] + 1'b1) >> 1;  // round half up
      if (half[l] > num_t'((1 << out_width) - 1)) begin
        res[l] = '1;  // a lone winner can reach 256
      end else begin
        res[l] = out_elem_t'(half[l]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_free) begin
      out_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_data <= res;
      out_last <= norm_in.last;
    end
  end

  // table clamp upstream keeps every divisor nonzero
  a_sum_nonzero: assert property (@(posedge clk) disable iff (rst)
    fire |-> sum != '0);

endmodule

/* verilog/softmax_fmt_pkg.sv */
package softmax_fmt_pkg;

  // input element, Q3.4 signed
  localparam int in_width = 8;
  localparam int in_frac  = 4;
  typedef logic signed [in_width-1:0] in_elem_t;

  // exponent value, Q8.8 unsigned
  localparam int exp_width = 16;
  localparam int exp_frac  = 8;
  typedef logic [exp_width-1:0] exp_elem_t;

  localparam int sum_width = exp_width + 3;  // room for eight terms
  typedef logic [sum_width-1:0] sum_t;

  // probability, Q0.8 unsigned
  localparam int out_width = 8;
  localparam int out_frac  = 8;
  typedef logic [out_width-1:0] out_elem_t;

  // table value for one input code, evaluated at elaboration only
  function automatic exp_elem_t exp_entry(input in_elem_t code);
    real x;
    real v;
    int  r;
    x = real'(code) / (2.0 ** in_frac);
    v = $exp(x) * (2.0 ** exp_frac);
    if (v > 65534.5) return '1;  // saturate large codes
    r = $rtoi(v + 0.5);
    if (r < 1) r = 1;  // never zero, keeps every vector sum nonzero
    return exp_elem_t'(r);
  endfunction

endpackage

/* verilog/softmax_top.sv */
`timescale 1ns/100ps

module softmax_top (
  input  logic                       clk,
  input  logic                       rst,
  input  softmax_vec_pkg::in_beat_t  in_data,
  input  logic                       in_valid,
  output logic                       in_ready,
  output softmax_vec_pkg::out_beat_t out_data,
  output logic                       out_valid,
  output logic                       out_last,
  input  logic                       out_ready
);
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  beat_if #(.payload_t(exp_beat_t)) exp_bus ();   // decode to execute
  beat_if #(.payload_t(exp_beat_t)) norm_bus ();  // execute to result

  sum_t sum;
  logic sum_valid;
  logic sum_ready;

  // decode: table lookup and beat position
  exp_decode i_exp_decode (
    .clk      (clk),
    .rst      (rst),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .exp_out  (exp_bus.src)
  );

  // execute: buffer beats, sum per vector
  sum_accumulate i_sum_accumulate (
    .clk       (clk),
    .rst       (rst),
    .exp_in    (exp_bus.snk),
    .norm_out  (norm_bus.src),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready)
  );

  // result: divide, round, register
  normalize_round i_normalize_round (
    .clk       (clk),
    .rst       (rst),
    .norm_in   (norm_bus.snk),
    .sum       (sum),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready)
  );

endmodule

/* verilog/softmax_vec_pkg.sv */
package softmax_vec_pkg;

  // vector geometry
  localparam int lanes         = 2;  // elements per beat
  localparam int vec_len       = 8;  // elements per vector
  localparam int beats_per_vec = vec_len / lanes;

  // buffering, counted in whole vectors
  localparam int fifo_vectors = 2;

  // position of a beat inside its vector
  typedef logic [$clog2(beats_per_vec)-1:0] beat_cnt_t;

  // per-lane beat payloads, lane 0 in the low bits
  typedef softmax_fmt_pkg::in_elem_t  [lanes-1:0] in_beat_t;
  typedef softmax_fmt_pkg::exp_elem_t [lanes-1:0] exp_beat_t;
  typedef softmax_fmt_pkg::out_elem_t [lanes-1:0] out_beat_t;

endpackage

/* verilog/sum_accumulate.sv */
`timescale 1ns/100ps

module sum_accumulate (
  input  logic                  clk,
  input  logic                  rst,
  beat_if.snk                   exp_in,
  beat_if.src                   norm_out,
  output softmax_fmt_pkg::sum_t sum,
  output logic                  sum_valid,
  input  logic                  sum_ready
);
  import softmax_fmt_pkg::*;
  import softmax_vec_pkg::*;

  // buffered beat keeps its vector end flag
  typedef struct packed {
    logic      last;
    exp_beat_t data;
  } exp_rec_t;

  exp_rec_t wr_rec;
  exp_rec_t rd_rec;
  logic     beat_ready;
  logic     take;
  logic     sum_push;
  logic     sum_room;
  sum_t     run_sum;
  sum_t     vec_total;

  assign exp_in.ready = beat_ready;  // gated by beat buffer room only
  assign take         = exp_in.valid && beat_ready;
  assign wr_rec       = '{last: exp_in.last, data: exp_in.data};

  beat_fifo #(
    .payload_t (exp_rec_t),
    .depth     (fifo_vectors * beats_per_vec)
  ) i_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (wr_rec),
    .in_valid  (exp_in.valid),
    .in_ready  (beat_ready),
    .out_data  (rd_rec),
    .out_valid (norm_out.valid),
    .out_ready (norm_out.ready)
  );

  assign norm_out.data = rd_rec.data;
  assign norm_out.last = rd_rec.last;

  // both lanes plus everything so far
  assign vec_total = run_sum + sum_t'(exp_in.data[0]) + sum_t'(exp_in.data[1]);
  assign sum_push  = take && exp_in.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_sum <= '0;
    end else if (take) begin
      run_sum <= exp_in.last ? '0 : vec_total;  // restart on vector end
    end
  end

  beat_fifo #(
    .payload_t (sum_t),
    .depth     (fifo_vectors)
  ) i_sum_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (vec_total),
    .in_valid  (sum_push),
    .in_ready  (sum_room),
    .out_data  (sum),
    .out_valid (sum_valid),
    .out_ready (sum_ready)
  );

  // relies on normalize_round popping one sum per drained vector
  a_sum_room: assert property (@(posedge clk) disable iff (rst)
    sum_push |-> sum_room);

endmodule
